// ==== Bender.yml ====
package:
  name: ts_core

sources:
  - hw/ts_pkg.sv
  - hw/zsignals.sv
  - hw/zports.sv
  - hw/raster_timer.sv
  - hw/zint.sv
  - hw/ts_core.sv
  - target: simulation
    files:
      - verification/tb_ts_core.sv

// ==== filelist.f ====
hw/ts_pkg.sv
hw/zsignals.sv
hw/zports.sv
hw/raster_timer.sv
hw/zint.sv
hw/ts_core.sv
verification/tb_ts_core.sv

// ==== hw/raster_timer.sv ====
`timescale 1ns/1ps

module raster_timer import ts_pkg::*; #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 320
) (
	input  logic              fclk,
	input  logic              arst_n,
	input  logic [LINE_W-1:0] vint_line,
	output logic              frame_start,
	output logic              line_match
);

	logic [HPOS_W-1:0] hcnt;
	logic [LINE_W-1:0] vcnt;
	logic              line_end;

	assign line_end = (hcnt == HPOS_W'(H_TOTAL - 1));

	////////////////////////////////////////////////////////////
	// tick and line counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (line_end) begin
			hcnt <= '0;
			if (vcnt == LINE_W'(V_TOTAL - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	// events at tick 0
	// line numbers past the frame are never reached by vcnt
	assign frame_start = (hcnt == '0) && (vcnt == '0);
	assign line_match  = (hcnt == '0) && (vcnt == vint_line);

endmodule

// ==== hw/ts_core.sv ====
`timescale 1ns/1ps

module ts_core import ts_pkg::*; #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 320
) (
	input  logic        fclk,
	input  logic        arst_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic [15:0] a,
	inout  wire  [7:0]  d,
	output logic        int_n,
	output logic [2:0]  border,
	output logic        beep
);

	logic              iord;
	logic              iowr_s;
	logic              intack;
	logic              intack_end;
	logic [7:0]        dout;
	logic              dout_en;
	logic [1:0]        intmask;
	logic [7:0]        im2v_base;
	logic [LINE_W-1:0] vint_line;
	logic              frame_start;
	logic              line_match;
	logic [7:0]        vec;
	logic              vec_en;

	zsignals i_zsignals (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.iorq_n     (iorq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.m1_n       (m1_n),
		.iord       (iord),
		.iowr       (),
		.iowr_s     (iowr_s),
		.intack     (intack),
		.intack_end (intack_end)
	);

	zports i_zports (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.a         (a),
		.din       (d),
		.iowr_s    (iowr_s),
		.iord      (iord),
		.dout      (dout),
		.dout_en   (dout_en),
		.intmask   (intmask),
		.im2v_base (im2v_base),
		.vint_line (vint_line),
		.border    (border),
		.beep      (beep)
	);

	raster_timer #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL)
	) i_raster_timer (
		.fclk        (fclk),
		.arst_n      (arst_n),
		.vint_line   (vint_line),
		.frame_start (frame_start),
		.line_match  (line_match)
	);

	zint i_zint (
		.fclk        (fclk),
		.arst_n      (arst_n),
		.frame_start (frame_start),
		.line_match  (line_match),
		.intmask     (intmask),
		.im2v_base   (im2v_base),
		.intack      (intack),
		.intack_end  (intack_end),
		.int_n       (int_n),
		.vec         (vec),
		.vec_en      (vec_en)
	);

	// vector during acknowledge, then port readback
	assign d = vec_en ? vec : (dout_en ? dout : 8'bzzzz_zzzz);

endmodule

// ==== hw/ts_pkg.sv ====
package ts_pkg;

	// raster geometry widths
	localparam int LINE_W = 9;
	localparam int HPOS_W = 9;

	////////////////////////////////////////////////////////////
	// port addresses
	////////////////////////////////////////////////////////////

	// #FE answers on any even address
	localparam logic [15:0] PORT_FE_MASK = 16'h0001;

	localparam logic [15:0] PORT_INTMASK = 16'h2AAF;
	localparam logic [15:0] PORT_IM2V    = 16'h2BAF;
	localparam logic [15:0] PORT_VINTL   = 16'h23AF;
	localparam logic [15:0] PORT_VINTH   = 16'h24AF;

	typedef enum logic [2:0] {
		SEL_NONE    = 3'd0,
		SEL_BORDER  = 3'd1,
		SEL_INTMASK = 3'd2,
		SEL_IM2V    = 3'd3,
		SEL_VINTL   = 3'd4,
		SEL_VINTH   = 3'd5
	} port_sel_e;

	////////////////////////////////////////////////////////////
	// interrupt sources
	////////////////////////////////////////////////////////////

	// value doubles as the mask bit index
	typedef enum logic {
		INT_FRM = 1'b0,
		INT_LIN = 1'b1
	} int_src_e;

	localparam logic [2:0] VEC_FRM = 3'd0;
	localparam logic [2:0] VEC_LIN = 3'd2;

endpackage

// ==== hw/zint.sv ====
`timescale 1ns/1ps

module zint import ts_pkg::*; (
	input  logic       fclk,
	input  logic       arst_n,
	input  logic       frame_start,
	input  logic       line_match,
	input  logic [1:0] intmask,
	input  logic [7:0] im2v_base,
	input  logic       intack,
	input  logic       intack_end,
	output logic       int_n,
	output logic [7:0] vec,
	output logic       vec_en
);

	logic [1:0] pending;
	logic [1:0] active;
	logic [1:0] clr;
	int_src_e   chosen;
	int_src_e   served_src;
	logic       served_vld;

	assign active = pending & intmask;

	// frame has priority
	always_comb begin
		if (active[INT_FRM])
			chosen = INT_FRM;
		else
			chosen = INT_LIN;
	end

	always_comb begin
		clr = 2'b00;
		if (intack_end && served_vld)
			clr[served_src] = 1'b1;
	end

	////////////////////////////////////////////////////////////
	// pending flags and int_n
	////////////////////////////////////////////////////////////

	// new event wins over a same-cycle clear
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 2'b00;
			int_n   <= 1'b1;
		end else begin
			pending <= (pending & ~clr) | {line_match, frame_start};
			int_n   <= !(|active);
		end
	end

	// source frozen for the whole acknowledge cycle
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			served_src <= INT_FRM;
			served_vld <= 1'b0;
		end else if (!intack) begin
			served_src <= chosen;
			served_vld <= |active;
		end
	end

	assign vec[7:3] = im2v_base[7:3];
	assign vec[2:0] = (served_src == INT_FRM) ? VEC_FRM : VEC_LIN;
	assign vec_en   = intack;

	a_mask_off: assert property (@(posedge fclk) disable iff (!arst_n)
		(intmask == 2'b00) |=> int_n);

endmodule

// ==== hw/zports.sv ====
`timescale 1ns/1ps

module zports import ts_pkg::*; (
	input  logic              fclk,
	input  logic              arst_n,
	input  logic [15:0]       a,
	input  logic [7:0]        din,
	input  logic              iowr_s,
	input  logic              iord,
	output logic [7:0]        dout,
	output logic              dout_en,
	output logic [1:0]        intmask,
	output logic [7:0]        im2v_base,
	output logic [LINE_W-1:0] vint_line,
	output logic [2:0]        border,
	output logic              beep
);

	port_sel_e sel;
	logic      wr_q;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	always_comb begin
		if (a == PORT_INTMASK)
			sel = SEL_INTMASK;
		else if (a == PORT_IM2V)
			sel = SEL_IM2V;
		else if (a == PORT_VINTL)
			sel = SEL_VINTL;
		else if (a == PORT_VINTH)
			sel = SEL_VINTH;
		else if ((a & PORT_FE_MASK) == 16'h0000)
			sel = SEL_BORDER;
		else
			sel = SEL_NONE;
	end

	// write lands one cycle after the strobe pulse
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			wr_q <= 1'b0;
		else
			wr_q <= iowr_s;
	end

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			intmask   <= '0;
			im2v_base <= '0;
			vint_line <= '0;
			border    <= '0;
			beep      <= 1'b0;
		end else if (wr_q) begin
			case (sel)
				SEL_BORDER: begin
					border <= din[2:0];
					beep   <= din[4];
				end
				SEL_INTMASK: intmask <= din[1:0];
				SEL_IM2V:    im2v_base <= din;
				SEL_VINTL:   vint_line[7:0] <= din;
				SEL_VINTH:   vint_line[LINE_W-1:8] <= din[LINE_W-9:0];
				default: ;
			endcase
		end
	end

	// readback, zero-extended
	always_comb begin
		case (sel)
			SEL_INTMASK: dout = {6'b0, intmask};
			SEL_IM2V:    dout = im2v_base;
			SEL_VINTL:   dout = vint_line[7:0];
			SEL_VINTH:   dout = 8'(vint_line[LINE_W-1:8]);
			default:     dout = 8'h00;
		endcase
	end

	assign dout_en = iord && (sel inside {SEL_INTMASK, SEL_IM2V, SEL_VINTL, SEL_VINTH});

	// readable registers all sit at #xxAF
	a_rd_mapped: assert property (@(posedge fclk) disable iff (!arst_n)
		dout_en |-> (a[7:0] == 8'hAF));

endmodule

// ==== hw/zsignals.sv ====
`timescale 1ns/1ps

module zsignals (
	input  logic fclk,
	input  logic arst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,
	output logic iord,
	output logic iowr,
	output logic iowr_s,
	output logic intack,
	output logic intack_end
);

	// strobes packed as {iorq_n, rd_n, wr_n, m1_n}
	logic [3:0] strb_s1;
	logic [3:0] strb_s2;
	logic       iowr_d;
	logic       intack_d;

	////////////////////////////////////////////////////////////
	// two-stage synchronizer
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			strb_s1 <= 4'hF;
			strb_s2 <= 4'hF;
		end else begin
			strb_s1 <= {iorq_n, rd_n, wr_n, m1_n};
			strb_s2 <= strb_s1;
		end
	end

	// cycle decode in fclk domain
	assign iord   = !strb_s2[3] && !strb_s2[2] && strb_s2[0];
	assign iowr   = !strb_s2[3] && !strb_s2[1] && strb_s2[0];
	assign intack = !strb_s2[3] && !strb_s2[0];

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			iowr_d   <= 1'b0;
			intack_d <= 1'b0;
		end else begin
			iowr_d   <= iowr;
			intack_d <= intack;
		end
	end

	// edge pulses
	assign iowr_s     = iowr && !iowr_d;
	assign intack_end = intack_d && !intack;

	a_rd_vs_wr: assert property (@(posedge fclk) disable iff (!arst_n)
		!(iord && iowr));

endmodule

// ==== verification/tb_ts_core.sv ====
`timescale 1ns/1ps

module tb_ts_core import ts_pkg::*; ();

	localparam int H_T       = 16;
	localparam int V_T       = 12;
	localparam int FRAME_CYC = H_T * V_T;
	localparam int LIMIT     = 30 * FRAME_CYC;

	logic       fclk;
	logic       arst_n;
	logic       iorq_n;
	logic       rd_n;
	logic       wr_n;
	logic       m1_n;
	logic [15:0] a;
	wire  [7:0] d;
	logic [7:0] d_drv;
	logic       d_oe;
	logic       int_n;
	logic [2:0] border;
	logic       beep;

	integer     seed = 53;
	int         cyc;
	int         pass_cnt;
	int         fail_cnt;
	event       ack_done;
	logic [7:0] exp_vec;
	logic [7:0] ack_vec;

	assign d = d_oe ? d_drv : 8'bzzzz_zzzz;

	ts_core #(
		.H_TOTAL (H_T),
		.V_TOTAL (V_T)
	) i_dut (
		.fclk   (fclk),
		.arst_n (arst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d      (d),
		.int_n  (int_n),
		.border (border),
		.beep   (beep)
	);

	always #5 fclk = ~fclk;

	// posedges since reset release, also the frame phase
	always @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
			if (cyc >= LIMIT) begin
				$display("timeout: run still busy after %0d cycles", cyc);
				$display("Test failed");
				$finish;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks and reference
	////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			fail_cnt++;
			$display("[ERROR] %0t ns %s: expected %02h, got %02h", $time, name, exp, act);
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_cnt++;
			$display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, exp, act);
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic check_line(input string name, input logic [LINE_W-1:0] exp,
			input logic [LINE_W-1:0] act);
		if (act !== exp) begin
			fail_cnt++;
			$display("[ERROR] %0t ns %s: expected %0d, got %0d", $time, name, exp, act);
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic report_failure(input string msg);
		fail_cnt++;
		$display("%0t ns: %s", $time, msg);
	endtask

	// frame wins over line, base keeps its top five bits
	function automatic logic [7:0] ref_vector(input logic [7:0] base, input logic [1:0] mask,
			input logic [1:0] pend);
		logic [1:0] act;
		logic [2:0] code;
		act = mask & pend;
		if (act[INT_FRM])
			code = VEC_FRM;
		else if (act[INT_LIN])
			code = VEC_LIN;
		else
			code = VEC_FRM;
		return {base[7:3], code};
	endfunction

	always begin
		@(ack_done);
		check_byte("d (IM2 vector)", exp_vec, ack_vec);
	end

	////////////////////////////////////////////////////////////
	// Z80 bus cycles
	////////////////////////////////////////////////////////////

	task automatic idle(input int n);
		repeat (n) @(negedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a      = addr;
		d_drv  = data;
		d_oe   = 1'b1;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		idle(6);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		d_oe   = 1'b0;
		idle(4);
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		idle(6);
		data   = d;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		idle(4);
	endtask

	task automatic int_ack();
		iorq_n = 1'b0;
		m1_n   = 1'b0;
		idle(6);
		ack_vec = d;
		-> ack_done;
		iorq_n = 1'b1;
		m1_n   = 1'b1;
		idle(4);
	endtask

	task automatic wait_int_low(input int max_cyc, output bit seen);
		seen = 1'b0;
		for (int i = 0; i < max_cyc && !seen; i++) begin
			@(negedge fclk);
			if (int_n === 1'b0)
				seen = 1'b1;
		end
	endtask

	task automatic expect_int_high(input int n);
		bit bad;
		bad = 1'b0;
		for (int i = 0; i < n && !bad; i++) begin
			@(negedge fclk);
			if (int_n !== 1'b1) begin
				report_failure("int_n fell while the interrupt mask was zero");
				bad = 1'b1;
			end
		end
	endtask

	task automatic wait_phase(input int ph);
		@(negedge fclk);
		while ((cyc % FRAME_CYC) != ph)
			@(negedge fclk);
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (fail_cnt == errs_before)
			$display("%-28s ok", name);
		else
			$display("%-28s %0d error(s)", name, fail_cnt - errs_before);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] rnd;
		logic [7:0]  data;
		logic [7:0]  base;
		logic [7:0]  rd_l;
		logic [7:0]  rd_h;
		logic [7:0]  rd_v;
		int          errs;
		bit          seen;

		fclk     = 1'b0;
		arst_n   = 1'b0;
		iorq_n   = 1'b1;
		rd_n     = 1'b1;
		wr_n     = 1'b1;
		m1_n     = 1'b1;
		a        = 16'h0000;
		d_drv    = 8'h00;
		d_oe     = 1'b0;
		pass_cnt = 0;
		fail_cnt = 0;
		exp_vec  = 8'h00;
		ack_vec  = 8'h00;
		idle(4);
		arst_n = 1'b1;
		idle(2);

		// border and beeper
		errs = fail_cnt;
		rnd  = $random(seed);
		data = rnd[7:0];
		io_write({rnd[15:8], 8'hFE}, data);
		check_byte("border", {5'b0, data[2:0]}, {5'b0, border});
		check_bit("beep", data[4], beep);
		io_write(PORT_IM2V, ~data);
		io_write(16'h12FF, ~data);
		check_byte("border", {5'b0, data[2:0]}, {5'b0, border});
		check_bit("beep", data[4], beep);
		end_test("test 1 port #FE", errs);

		// register readback
		errs = fail_cnt;
		rnd  = $random(seed);
		io_write(PORT_INTMASK, rnd[7:0]);
		io_read(PORT_INTMASK, rd_v);
		check_byte("intmask", {6'b0, rnd[1:0]}, rd_v);
		io_write(PORT_IM2V, rnd[15:8]);
		io_read(PORT_IM2V, rd_v);
		check_byte("im2v_base", rnd[15:8], rd_v);
		rnd = $random(seed);
		io_write(PORT_VINTL, rnd[7:0]);
		io_write(PORT_VINTH, rnd[15:8]);
		io_read(PORT_VINTL, rd_l);
		io_read(PORT_VINTH, rd_h);
		check_byte("vint_line low", rnd[7:0], rd_l);
		check_byte("vint_line high", {7'b0, rnd[8]}, rd_h);
		check_line("vint_line", {rnd[8], rnd[7:0]}, {rd_h[0], rd_l});
		io_read(16'h12FF, rd_v);
		if (rd_v !== 8'bzzzz_zzzz)
			report_failure("read of an unmapped port drove the data bus");
		end_test("test 2 register readback", errs);

		// frame interrupt
		errs = fail_cnt;
		rnd  = $random(seed);
		base = rnd[7:0];
		io_write(PORT_IM2V, base);
		io_write(PORT_INTMASK, 8'h01);
		wait_int_low(FRAME_CYC, seen);
		if (!seen)
			report_failure("int_n did not fall within one frame");
		wait_phase(20);
		exp_vec = ref_vector(base, 2'b01, 2'b01);
		int_ack();
		idle(2);
		check_bit("int_n", 1'b1, int_n);
		wait_int_low(2 * FRAME_CYC, seen);
		if (!seen)
			report_failure("int_n did not fall at the next frame");
		else if ((cyc % FRAME_CYC) != 2)
			report_failure("int_n fell away from a frame start");
		end_test("test 3 frame interrupt", errs);

		// line interrupt, then masked off
		errs = fail_cnt;
		io_write(PORT_VINTL, 8'd5);
		io_write(PORT_VINTH, 8'd0);
		io_read(PORT_VINTL, rd_l);
		io_read(PORT_VINTH, rd_h);
		check_line("vint_line", 5, {rd_h[0], rd_l});
		io_write(PORT_INTMASK, 8'h02);
		wait_int_low(FRAME_CYC + 4, seen);
		if (!seen)
			report_failure("int_n did not fall for the line interrupt");
		wait_phase(100);
		exp_vec = ref_vector(base, 2'b10, 2'b11);
		int_ack();
		idle(2);
		check_bit("int_n", 1'b1, int_n);
		wait_int_low(2 * FRAME_CYC, seen);
		if (!seen)
			report_failure("int_n did not fall at line 5");
		else if ((cyc % FRAME_CYC) != 5 * H_T + 2)
			report_failure("line interrupt fell away from line 5");
		io_write(PORT_INTMASK, 8'h00);
		expect_int_high(2 * FRAME_CYC);
		end_test("test 4 line interrupt", errs);

		// both sources at line 0
		errs = fail_cnt;
		io_write(PORT_VINTL, 8'd0);
		io_write(PORT_VINTH, 8'd0);
		io_write(PORT_INTMASK, 8'h03);
		wait_int_low(FRAME_CYC + 4, seen);
		if (!seen)
			report_failure("int_n did not fall with both sources enabled");
		wait_phase(20);
		exp_vec = ref_vector(base, 2'b11, 2'b11);
		int_ack();
		idle(2);
		check_bit("int_n", 1'b0, int_n);
		exp_vec = ref_vector(base, 2'b11, 2'b10);
		int_ack();
		idle(2);
		check_bit("int_n", 1'b1, int_n);
		end_test("test 5 priority", errs);

		$display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
